//--- Bender.yml
package:
  name: npc_core

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/npc_pkg.sv
      - verilog/npc_ifu.sv
      - verilog/npc_idu.sv
      - verilog/npc_regfile.sv
      - verilog/npc_exu.sv
      - verilog/npc_bru.sv
      - verilog/npc_lsu.sv
      - verilog/npc_core.sv
  - target: simulation
    files:
      - sim/npc_asserts.sv
      - sim/npc_tb.sv

//--- sim/npc_asserts.sv
// NPC core port checker
`timescale 1ns/1ps
`include "npc_defs.svh"

module npc_asserts
  import npc_pkg::*;
(
  input logic     i_clk,
  input logic     i_rst_n,
  input xlen_t    o_imem_addr,
  input inst_t    i_imem_rdata,
  input xlen_t    o_dmem_addr,
  input xlen_t    o_dmem_wdata,
  input logic     o_dmem_wen,
  input logic     o_dmem_ren,
  input logic     o_dmem_size,
  input logic     o_wb_en,
  input reg_idx_t o_wb_idx,
  input xlen_t    o_wb_data,
  input logic     o_halt,
  input logic     o_invalid
);

  localparam inst_t EBREAK = 32'h0010_0073;

  int         err_count = 0;
  xlen_t      shadow [0:31];
  logic [6:0] op;
  logic [2:0] f3;
  logic [6:0] f7;
  reg_idx_t   rd;
  xlen_t      rs1_v;
  xlen_t      rs2_v;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      sum_rr;
  xlen_t      arith_exp;
  xlen_t      next_exp;
  xlen_t      load_exp;
  logic       is_valid;
  logic       is_arith;
  logic       is_link;
  logic       is_branch;
  logic       is_mem;
  logic       is_store;
  logic       is_load;
  logic       br_cond;
  logic       run_q;
  logic       halted_q;
  logic       st_valid_q;
  logic       st_dword_q;
  xlen_t      exp_next_q;
  xlen_t      st_addr_q;
  xlen_t      st_data_q;

  assign op     = i_imem_rdata[6:0];
  assign f3     = i_imem_rdata[14:12];
  assign f7     = i_imem_rdata[31:25];
  assign rd     = i_imem_rdata[11:7];
  assign rs1_v  = shadow[i_imem_rdata[19:15]];
  assign rs2_v  = shadow[i_imem_rdata[24:20]];
  assign sum_rr = rs1_v + rs2_v;
  assign imm_i  = {{52{i_imem_rdata[31]}}, i_imem_rdata[31:20]};
  assign imm_s  = {{52{i_imem_rdata[31]}}, i_imem_rdata[31:25], i_imem_rdata[11:7]};
  assign imm_b  = {{52{i_imem_rdata[31]}}, i_imem_rdata[7], i_imem_rdata[30:25],
                   i_imem_rdata[11:8], 1'b0};
  assign imm_u  = {{32{i_imem_rdata[31]}}, i_imem_rdata[31:12], 12'b0};
  assign imm_j  = {{44{i_imem_rdata[31]}}, i_imem_rdata[19:12], i_imem_rdata[20],
                   i_imem_rdata[30:21], 1'b0};

  assign is_link   = !o_halt && ((op == `NPC_OP_JAL) || (op == `NPC_OP_JALR && f3 == 3'b000));
  assign is_branch = (op == `NPC_OP_BRANCH) && (f3 inside {3'b000, 3'b001, 3'b100, 3'b101});
  assign is_mem    = !o_halt && (op == `NPC_OP_LOAD || op == `NPC_OP_STORE) &&
                     (f3[2:1] == 2'b01);
  assign is_store  = !o_halt && (op == `NPC_OP_STORE) && (f3[2:1] == 2'b01);
  assign is_load   = !o_halt && (op == `NPC_OP_LOAD) && (f3[2:1] == 2'b01) && (rd != '0) &&
                     st_valid_q && (rs1_v + imm_i == st_addr_q) && (st_dword_q || !f3[0]);
  assign load_exp  = f3[0] ? st_data_q : {{32{st_data_q[31]}}, st_data_q[31:0]};

  // Encodings of the supported instruction set.
  always_comb begin
    case (op)
      `NPC_OP_LUI, `NPC_OP_AUIPC, `NPC_OP_JAL: is_valid = 1'b1;
      `NPC_OP_JALR:   is_valid = (f3 == 3'b000);
      `NPC_OP_BRANCH: is_valid = (f3 inside {3'b000, 3'b001, 3'b100, 3'b101});
      `NPC_OP_LOAD, `NPC_OP_STORE: is_valid = (f3[2:1] == 2'b01);
      `NPC_OP_IMM:    is_valid = (f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111});
      `NPC_OP_REG:    is_valid = (f7 == 7'h00 && (f3 inside {3'b000, 3'b010, 3'b100,
                                                            3'b110, 3'b111})) ||
                                 (f7 == 7'h20 && f3 == 3'b000);
      `NPC_OP_IMM32:  is_valid = (f3 == 3'b000);
      `NPC_OP_REG32:  is_valid = (f7 == 7'h00 && f3 == 3'b000);
      default:        is_valid = 1'b0;
    endcase
  end

  // =====================================================================
  // Reference results from the RV64I rules
  // =====================================================================
  always_comb begin
    is_arith  = !o_halt && (rd != '0);
    arith_exp = '0;
    if (op == `NPC_OP_IMM && f3 == 3'b000)
      arith_exp = rs1_v + imm_i;
    else if (op == `NPC_OP_IMM && f3 == 3'b010)
      arith_exp = {63'd0, $signed(rs1_v) < $signed(imm_i)};
    else if (op == `NPC_OP_LUI)
      arith_exp = imm_u;
    else if (op == `NPC_OP_AUIPC)
      arith_exp = o_imem_addr + imm_u;
    else if (op == `NPC_OP_REG && f3 == 3'b000 && f7 == 7'h00)
      arith_exp = sum_rr;
    else if (op == `NPC_OP_REG && f3 == 3'b000 && f7 == 7'h20)
      arith_exp = rs1_v - rs2_v;
    else if (op == `NPC_OP_REG && f3 == 3'b100 && f7 == 7'h00)
      arith_exp = rs1_v ^ rs2_v;
    else if (op == `NPC_OP_REG32 && f3 == 3'b000 && f7 == 7'h00)
      arith_exp = {{32{sum_rr[31]}}, sum_rr[31:0]};
    else
      is_arith = 1'b0;
  end

  always_comb begin
    case (f3)
      3'b000:  br_cond = (rs1_v == rs2_v);
      3'b001:  br_cond = (rs1_v != rs2_v);
      3'b100:  br_cond = ($signed(rs1_v) < $signed(rs2_v));
      default: br_cond = ($signed(rs1_v) >= $signed(rs2_v));
    endcase
    if (o_halt)
      next_exp = o_imem_addr;
    else if (op == `NPC_OP_JAL)
      next_exp = o_imem_addr + imm_j;
    else if (is_link)
      next_exp = (rs1_v + imm_i) & ~64'd1;
    else if (is_branch && br_cond)
      next_exp = o_imem_addr + imm_b;
    else
      next_exp = o_imem_addr + 64'd4;
  end

  // Register shadow and last store, both fed from the core's ports.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        shadow[i] <= '0;
      end
      run_q      <= 1'b0;
      halted_q   <= 1'b0;
      exp_next_q <= '0;
      st_valid_q <= 1'b0;
      st_dword_q <= 1'b0;
      st_addr_q  <= '0;
      st_data_q  <= '0;
    end else begin
      if (o_wb_en && o_wb_idx != '0) begin
        shadow[o_wb_idx] <= o_wb_data;
      end
      run_q      <= 1'b1;
      halted_q   <= o_halt;
      exp_next_q <= next_exp;
      if (is_store) begin
        st_valid_q <= 1'b1;
        st_dword_q <= f3[0];
        st_addr_q  <= rs1_v + imm_s;
        st_data_q  <= rs2_v;
      end
    end
  end

  // =====================================================================
  // Port assertions
  // =====================================================================
  a_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |->
      o_imem_addr == `NPC_RESET_PC && !o_dmem_wen && !o_wb_en && !o_halt)
    else begin
      err_count++;
      $error("fetch address or enables are wrong right after reset release");
    end
  a_next_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      run_q |-> o_imem_addr == exp_next_q)
    else begin
      err_count++;
      $error("MISMATCH o_imem_addr exp %h got %h", $sampled(exp_next_q), $sampled(o_imem_addr));
    end
  a_link: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      is_link && rd != '0 |-> o_wb_en && o_wb_idx == rd && o_wb_data == o_imem_addr + 64'd4)
    else begin
      err_count++;
      $error("MISMATCH o_wb_en %h o_wb_idx exp %h got %h o_wb_data exp %h got %h",
             $sampled(o_wb_en), $sampled(rd), $sampled(o_wb_idx),
             $sampled(o_imem_addr) + 64'd4, $sampled(o_wb_data));
    end
  a_arith: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      is_arith |-> o_wb_en && o_wb_idx == rd && o_wb_data == arith_exp)
    else begin
      err_count++;
      $error("MISMATCH o_wb_en %h o_wb_idx exp %h got %h o_wb_data exp %h got %h",
             $sampled(o_wb_en), $sampled(rd), $sampled(o_wb_idx),
             $sampled(arith_exp), $sampled(o_wb_data));
    end
  a_no_x0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_wb_en && o_wb_idx == '0))
    else begin
      err_count++;
      $error("write-back to register x0 was signalled");
    end
  a_mem_ctl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      is_mem |-> o_dmem_wen == is_store && o_dmem_ren == !is_store && o_dmem_size == f3[0])
    else begin
      err_count++;
      $error("MISMATCH o_dmem_wen exp %h got %h o_dmem_ren exp %h got %h o_dmem_size exp %h got %h",
             $sampled(is_store), $sampled(o_dmem_wen), $sampled(!is_store),
             $sampled(o_dmem_ren), $sampled(f3[0]), $sampled(o_dmem_size));
    end
  a_store: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      is_store |-> o_dmem_wen && o_dmem_addr == rs1_v + imm_s && o_dmem_wdata == rs2_v)
    else begin
      err_count++;
      $error("MISMATCH o_dmem_addr exp %h got %h o_dmem_wdata exp %h got %h",
             $sampled(rs1_v + imm_s), $sampled(o_dmem_addr), $sampled(rs2_v),
             $sampled(o_dmem_wdata));
    end
  a_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      is_load |-> o_dmem_addr == st_addr_q && o_wb_en && o_wb_data == load_exp)
    else begin
      err_count++;
      $error("MISMATCH o_wb_en %h o_dmem_addr exp %h got %h o_wb_data exp %h got %h",
             $sampled(o_wb_en), $sampled(st_addr_q), $sampled(o_dmem_addr),
             $sampled(load_exp), $sampled(o_wb_data));
    end
  a_halt_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      halted_q |-> o_halt && !o_wb_en && !o_dmem_wen && !o_dmem_ren)
    else begin
      err_count++;
      $error("core left the halt state or raised an enable while halted");
    end
  a_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !halted_q && is_valid |-> !o_halt && !o_invalid)
    else begin
      err_count++;
      $error("a supported instruction raised halt or invalid");
    end
  a_ebreak: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_imem_rdata == EBREAK |-> o_halt && !o_invalid)
    else begin
      err_count++;
      $error("EBREAK did not halt the core cleanly");
    end
  a_invalid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !is_valid && i_imem_rdata != EBREAK |-> o_halt && o_invalid)
    else begin
      err_count++;
      $error("invalid instruction word did not raise halt and invalid");
    end

endmodule

//--- sim/npc_tb.sv
// NPC core testbench
`timescale 1ns/1ps

module npc_tb
  import npc_pkg::*;
();

  localparam int    PROG_LEN        = 27;
  localparam int    RESET_CYCLES    = 10;
  localparam int    WATCHDOG_CYCLES = 2 * (PROG_LEN * 10 + RESET_CYCLES);
  localparam inst_t EBREAK          = 32'h0010_0073;

  // Arithmetic, AUIPC addressing, SD/LD and SW/LW pairs, branches, JAL, JALR, EBREAK.
  localparam inst_t PROGRAM [PROG_LEN] = '{
    32'h0000_1463, 32'h0050_0093, 32'hFFD0_0113, 32'h0020_81B3,
    32'h4020_8233, 32'h0020_C333, 32'h7FFF_F3B7, 32'h0073_843B,
    32'h0000_1297, 32'h0042_B023, 32'h0002_B483, 32'h0022_A423,
    32'h0082_A503, 32'h0010_8463, 32'h0010_0593, 32'h0011_4463,
    32'h0010_0593, 32'h0011_5463, 32'h0020_9463, 32'h0010_0593,
    32'h0080_066F, 32'h0010_0593, 32'h00C6_0713, 32'h0057_06E7,
    32'h0010_0593, 32'h0001_2793, 32'h0010_0073
  };

  logic     clk = 1'b0;
  logic     rst_n;
  xlen_t    imem_addr;
  inst_t    imem_rdata;
  xlen_t    dmem_addr;
  xlen_t    dmem_wdata;
  logic     dmem_wen;
  logic     dmem_ren;
  logic     dmem_size;
  xlen_t    dmem_rdata;
  logic     wb_en;
  reg_idx_t wb_idx;
  xlen_t    wb_data;
  logic     halt;
  logic     invalid;
  int       fail_count;
  inst_t    rom [64];
  xlen_t    dram [256];

  always #5 clk = ~clk;

  // Both memories answer in the same cycle. A word read of the upper half is shifted down.
  assign imem_rdata = rom[imem_addr[7:2]];
  assign dmem_rdata = (!dmem_size && dmem_addr[2]) ? (dram[dmem_addr[10:3]] >> 32) :
                      dram[dmem_addr[10:3]];

  always @(posedge clk) begin
    if (dmem_wen) begin
      if (dmem_size)
        dram[dmem_addr[10:3]] <= dmem_wdata;
      else if (dmem_addr[2])
        dram[dmem_addr[10:3]][63:32] <= dmem_wdata[31:0];
      else
        dram[dmem_addr[10:3]][31:0] <= dmem_wdata[31:0];
    end
  end

  npc_core u_dut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_wen   (dmem_wen),
    .o_dmem_ren   (dmem_ren),
    .o_dmem_size  (dmem_size),
    .i_dmem_rdata (dmem_rdata),
    .o_wb_en      (wb_en),
    .o_wb_idx     (wb_idx),
    .o_wb_data    (wb_data),
    .o_halt       (halt),
    .o_invalid    (invalid)
  );

  bind npc_core npc_asserts u_chk (.*);

  task automatic load_memories();
    for (int i = 0; i < 64; i++) begin
      rom[i] = (i < PROG_LEN) ? PROGRAM[i] : EBREAK;
    end
    for (int i = 0; i < 256; i++) begin
      dram[i] = {$urandom(), $urandom()};
    end
  endtask

  task automatic apply_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_for_halt();
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  initial begin
    void'($urandom(76));
    rst_n = 1'b0;
    load_memories();
    apply_reset();
    wait_for_halt();
    // Second run is bne, addi, then an all-zero word.
    rst_n  = 1'b0;
    rom[2] = 32'h0;
    apply_reset();
    wait_for_halt();
    fail_count = u_dut.u_chk.err_count;
    $display("run complete, %0d assertion failures", fail_count);
    if (fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, core never halted, %0d assertion failures", u_dut.u_chk.err_count);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/npc_pkg.sv
verilog/npc_ifu.sv
verilog/npc_idu.sv
verilog/npc_regfile.sv
verilog/npc_exu.sv
verilog/npc_bru.sv
verilog/npc_lsu.sv
verilog/npc_core.sv
sim/npc_asserts.sv
sim/npc_tb.sv

//--- verilog/npc_bru.sv
// NPC branch unit
`timescale 1ns/1ps

module npc_bru
  import npc_pkg::*;
(
  input  xlen_t  i_pc,
  input  xlen_t  i_rs1_data,
  input  xlen_t  i_imm,
  input  br_op_e i_br_op,
  input  logic   i_zero,
  input  logic   i_less,
  output logic   o_taken,
  output xlen_t  o_target
);

  xlen_t pc_rel;
  xlen_t reg_rel;

  assign pc_rel  = i_pc + i_imm;
  assign reg_rel = i_rs1_data + i_imm;

  always_comb begin
    case (i_br_op)
      BR_JAL:  o_taken = 1'b1;
      BR_JALR: o_taken = 1'b1;
      BR_BEQ:  o_taken = i_zero;
      BR_BNE:  o_taken = ~i_zero;
      BR_BLT:  o_taken = i_less;
      BR_BGE:  o_taken = ~i_less;
      default: o_taken = 1'b0;
    endcase
  end

  // JALR clears bit 0 of the computed address.
  assign o_target = (i_br_op == BR_JALR) ? {reg_rel[63:1], 1'b0} : pc_rel;

endmodule

//--- verilog/npc_core.sv
// NPC single cycle core
`timescale 1ns/1ps

module npc_core
  import npc_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  output xlen_t    o_imem_addr,
  input  inst_t    i_imem_rdata,
  output xlen_t    o_dmem_addr,
  output xlen_t    o_dmem_wdata,
  output logic     o_dmem_wen,
  output logic     o_dmem_ren,
  output logic     o_dmem_size,
  input  xlen_t    i_dmem_rdata,
  output logic     o_wb_en,
  output reg_idx_t o_wb_idx,
  output xlen_t    o_wb_data,
  output logic     o_halt,
  output logic     o_invalid
);

  xlen_t    pc_plus4;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  xlen_t    imm;
  alu_op_e  alu_op;
  logic     alu_a_pc;
  logic     alu_b_imm;
  logic     word_cut;
  br_op_e   br_op;
  wb_sel_e  wb_sel;
  logic     reg_wen;
  logic     mem_wen;
  logic     mem_ren;
  logic     mem_size;
  logic     ebreak;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  xlen_t    alu_result;
  logic     alu_zero;
  logic     alu_less;
  logic     br_taken;
  xlen_t    br_target;

  npc_ifu u_ifu (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_halt      (ebreak | o_invalid),
    .i_br_taken  (br_taken),
    .i_br_target (br_target),
    .o_pc        (o_imem_addr),
    .o_pc_plus4  (pc_plus4),
    .o_halted    (o_halt)
  );

  npc_idu u_idu (
    .i_inst      (i_imem_rdata),
    .i_halted    (o_halt),
    .o_rs1_idx   (rs1_idx),
    .o_rs2_idx   (rs2_idx),
    .o_rd_idx    (rd_idx),
    .o_imm       (imm),
    .o_alu_op    (alu_op),
    .o_alu_a_pc  (alu_a_pc),
    .o_alu_b_imm (alu_b_imm),
    .o_word_cut  (word_cut),
    .o_br_op     (br_op),
    .o_wb_sel    (wb_sel),
    .o_reg_wen   (reg_wen),
    .o_mem_wen   (mem_wen),
    .o_mem_ren   (mem_ren),
    .o_mem_size  (mem_size),
    .o_ebreak    (ebreak),
    .o_invalid   (o_invalid)
  );

  // The write port is fed from the write-back outputs.
  npc_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rs1_idx  (rs1_idx),
    .i_rs2_idx  (rs2_idx),
    .i_wen      (o_wb_en),
    .i_rd_idx   (o_wb_idx),
    .i_wdata    (o_wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  npc_exu u_exu (
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_imm       (imm),
    .i_pc        (o_imem_addr),
    .i_alu_op    (alu_op),
    .i_alu_a_pc  (alu_a_pc),
    .i_alu_b_imm (alu_b_imm),
    .i_word_cut  (word_cut),
    .o_result    (alu_result),
    .o_zero      (alu_zero),
    .o_less      (alu_less)
  );

  npc_bru u_bru (
    .i_pc       (o_imem_addr),
    .i_rs1_data (rs1_data),
    .i_imm      (imm),
    .i_br_op    (br_op),
    .i_zero     (alu_zero),
    .i_less     (alu_less),
    .o_taken    (br_taken),
    .o_target   (br_target)
  );

  npc_lsu u_lsu (
    .i_alu_result (alu_result),
    .i_rs2_data   (rs2_data),
    .i_pc_plus4   (pc_plus4),
    .i_mem_wen    (mem_wen),
    .i_mem_ren    (mem_ren),
    .i_mem_size   (mem_size),
    .i_wb_sel     (wb_sel),
    .i_reg_wen    (reg_wen),
    .i_rd_idx     (rd_idx),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_wen   (o_dmem_wen),
    .o_dmem_ren   (o_dmem_ren),
    .o_dmem_size  (o_dmem_size),
    .o_wb_en      (o_wb_en),
    .o_wb_idx     (o_wb_idx),
    .o_wb_data    (o_wb_data)
  );

endmodule

//--- verilog/npc_defs.svh
// NPC core parameters
`ifndef NPC_DEFS_SVH
`define NPC_DEFS_SVH

// Data path width and the PC value after reset.
`define NPC_XLEN     64
`define NPC_RESET_PC 64'h0000_0000_8000_0000

// =====================================================================
// Major opcodes, bits [6:0] of the instruction
// =====================================================================
`define NPC_OP_LUI     7'b0110111
`define NPC_OP_AUIPC   7'b0010111
`define NPC_OP_JAL     7'b1101111
`define NPC_OP_JALR    7'b1100111
`define NPC_OP_BRANCH  7'b1100011
`define NPC_OP_LOAD    7'b0000011
`define NPC_OP_STORE   7'b0100011
`define NPC_OP_IMM     7'b0010011
`define NPC_OP_REG     7'b0110011
`define NPC_OP_IMM32   7'b0011011
`define NPC_OP_REG32   7'b0111011
`define NPC_OP_SYSTEM  7'b1110011

`endif

//--- verilog/npc_exu.sv
// NPC execute unit
`timescale 1ns/1ps
`include "npc_defs.svh"

module npc_exu
  import npc_pkg::*;
(
  input  xlen_t   i_rs1_data,
  input  xlen_t   i_rs2_data,
  input  xlen_t   i_imm,
  input  xlen_t   i_pc,
  input  alu_op_e i_alu_op,
  input  logic    i_alu_a_pc,
  input  logic    i_alu_b_imm,
  input  logic    i_word_cut,
  output xlen_t   o_result,
  output logic    o_zero,
  output logic    o_less
);

  xlen_t op_a;
  xlen_t op_b;
  xlen_t alu_raw;
  xlen_t diff;
  logic  slt;

  assign op_a = i_alu_a_pc  ? i_pc  : i_rs1_data;
  assign op_b = i_alu_b_imm ? i_imm : i_rs2_data;
  assign slt  = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    alu_raw = op_a + op_b;
      ALU_SUB:    alu_raw = op_a - op_b;
      ALU_AND:    alu_raw = op_a & op_b;
      ALU_OR:     alu_raw = op_a | op_b;
      ALU_XOR:    alu_raw = op_a ^ op_b;
      ALU_SLT:    alu_raw = {{(`NPC_XLEN-1){1'b0}}, slt};
      ALU_PASS_B: alu_raw = op_b;
      default:    alu_raw = '0;
    endcase
  end

  // W instructions keep the low word and sign-extend it.
  assign o_result = i_word_cut ? {{(`NPC_XLEN-32){alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  // Branch flags from rs1 - rs2. On a sign mismatch the rs1 sign decides.
  assign diff   = i_rs1_data - i_rs2_data;
  assign o_zero = (diff == '0);
  assign o_less = (i_rs1_data[`NPC_XLEN-1] ^ i_rs2_data[`NPC_XLEN-1]) ?
                  i_rs1_data[`NPC_XLEN-1] : diff[`NPC_XLEN-1];

endmodule

//--- verilog/npc_idu.sv
// NPC instruction decoder
`timescale 1ns/1ps
`include "npc_defs.svh"

module npc_idu
  import npc_pkg::*;
(
  input  inst_t    i_inst,
  input  logic     i_halted,
  output reg_idx_t o_rs1_idx,
  output reg_idx_t o_rs2_idx,
  output reg_idx_t o_rd_idx,
  output xlen_t    o_imm,
  output alu_op_e  o_alu_op,
  output logic     o_alu_a_pc,
  output logic     o_alu_b_imm,
  output logic     o_word_cut,
  output br_op_e   o_br_op,
  output wb_sel_e  o_wb_sel,
  output logic     o_reg_wen,
  output logic     o_mem_wen,
  output logic     o_mem_ren,
  output logic     o_mem_size,
  output logic     o_ebreak,
  output logic     o_invalid
);

  localparam inst_t EBREAK_INST = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       reg_wen_raw;
  logic       mem_wen_raw;
  logic       mem_ren_raw;
  logic       enable_ok;

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign funct7    = i_inst[31:25];
  assign o_rd_idx  = i_inst[11:7];
  assign o_rs1_idx = i_inst[19:15];
  assign o_rs2_idx = i_inst[24:20];

  // =====================================================================
  // Immediate formats
  // =====================================================================
  assign imm_i = {{(`NPC_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`NPC_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`NPC_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`NPC_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`NPC_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  // =====================================================================
  // Control decode
  // =====================================================================
  always_comb begin
    o_imm       = '0;
    o_alu_op    = ALU_ADD;
    o_alu_a_pc  = 1'b0;
    o_alu_b_imm = 1'b0;
    o_word_cut  = 1'b0;
    o_br_op     = BR_NONE;
    o_wb_sel    = WB_ALU;
    o_mem_size  = 1'b0;
    o_ebreak    = 1'b0;
    o_invalid   = 1'b0;
    reg_wen_raw = 1'b0;
    mem_wen_raw = 1'b0;
    mem_ren_raw = 1'b0;
    case (opcode)
      `NPC_OP_LUI: begin
        o_imm       = imm_u;
        o_alu_op    = ALU_PASS_B;
        o_alu_b_imm = 1'b1;
        reg_wen_raw = 1'b1;
      end
      `NPC_OP_AUIPC: begin
        o_imm       = imm_u;
        o_alu_a_pc  = 1'b1;
        o_alu_b_imm = 1'b1;
        reg_wen_raw = 1'b1;
      end
      `NPC_OP_JAL: begin
        o_imm       = imm_j;
        o_br_op     = BR_JAL;
        o_wb_sel    = WB_PC4;
        reg_wen_raw = 1'b1;
      end
      `NPC_OP_JALR: begin
        o_imm       = imm_i;
        o_br_op     = BR_JALR;
        o_wb_sel    = WB_PC4;
        reg_wen_raw = 1'b1;
        o_invalid   = (funct3 != 3'b000);
      end
      `NPC_OP_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'b000:  o_br_op = BR_BEQ;
          3'b001:  o_br_op = BR_BNE;
          3'b100:  o_br_op = BR_BLT;
          3'b101:  o_br_op = BR_BGE;
          default: o_invalid = 1'b1;
        endcase
      end
      `NPC_OP_LOAD: begin
        o_imm       = imm_i;
        o_alu_b_imm = 1'b1;
        o_wb_sel    = WB_LOAD;
        mem_ren_raw = 1'b1;
        reg_wen_raw = 1'b1;
        o_mem_size  = funct3[0];
        o_invalid   = (funct3[2:1] != 2'b01);
      end
      `NPC_OP_STORE: begin
        o_imm       = imm_s;
        o_alu_b_imm = 1'b1;
        mem_wen_raw = 1'b1;
        o_mem_size  = funct3[0];
        o_invalid   = (funct3[2:1] != 2'b01);
      end
      `NPC_OP_IMM: begin
        o_imm       = imm_i;
        o_alu_b_imm = 1'b1;
        reg_wen_raw = 1'b1;
        case (funct3)
          3'b000:  o_alu_op = ALU_ADD;
          3'b010:  o_alu_op = ALU_SLT;
          3'b100:  o_alu_op = ALU_XOR;
          3'b110:  o_alu_op = ALU_OR;
          3'b111:  o_alu_op = ALU_AND;
          default: o_invalid = 1'b1;
        endcase
      end
      `NPC_OP_REG: begin
        reg_wen_raw = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_alu_op = ALU_ADD;
          10'b0100000_000: o_alu_op = ALU_SUB;
          10'b0000000_010: o_alu_op = ALU_SLT;
          10'b0000000_100: o_alu_op = ALU_XOR;
          10'b0000000_110: o_alu_op = ALU_OR;
          10'b0000000_111: o_alu_op = ALU_AND;
          default:         o_invalid = 1'b1;
        endcase
      end
      `NPC_OP_IMM32: begin
        o_imm       = imm_i;
        o_alu_b_imm = 1'b1;
        o_word_cut  = 1'b1;
        reg_wen_raw = 1'b1;
        o_invalid   = (funct3 != 3'b000);
      end
      `NPC_OP_REG32: begin
        o_word_cut  = 1'b1;
        reg_wen_raw = 1'b1;
        o_invalid   = ({funct7, funct3} != 10'b0000000_000);
      end
      `NPC_OP_SYSTEM: begin
        o_ebreak  = (i_inst == EBREAK_INST);
        o_invalid = (i_inst != EBREAK_INST);
      end
      default: o_invalid = 1'b1;
    endcase
  end

  // Nothing commits once halted, and x0 is never a write-back target.
  assign enable_ok = ~i_halted & ~o_invalid;
  assign o_reg_wen = reg_wen_raw & enable_ok & (o_rd_idx != '0);
  assign o_mem_wen = mem_wen_raw & enable_ok;
  assign o_mem_ren = mem_ren_raw & enable_ok;

endmodule

//--- verilog/npc_ifu.sv
// NPC instruction fetch unit
`timescale 1ns/1ps
`include "npc_defs.svh"

module npc_ifu
  import npc_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_halt,
  input  logic  i_br_taken,
  input  xlen_t i_br_target,
  output xlen_t o_pc,
  output xlen_t o_pc_plus4,
  output logic  o_halted
);

  xlen_t pc_q;
  xlen_t pc_next;
  logic  halted_q;

  // The core counts as halted from the cycle the halt decodes.
  assign o_halted   = halted_q | i_halt;
  assign o_pc       = pc_q;
  assign o_pc_plus4 = pc_q + xlen_t'(4);

  always_comb begin
    if (o_halted) begin
      pc_next = pc_q;
    end else if (i_br_taken) begin
      pc_next = i_br_target;
    end else begin
      pc_next = o_pc_plus4;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q     <= `NPC_RESET_PC;
      halted_q <= 1'b0;
    end else begin
      pc_q     <= pc_next;
      halted_q <= o_halted;
    end
  end

endmodule

//--- verilog/npc_lsu.sv
// NPC load store unit
`timescale 1ns/1ps
`include "npc_defs.svh"

module npc_lsu
  import npc_pkg::*;
(
  input  xlen_t    i_alu_result,
  input  xlen_t    i_rs2_data,
  input  xlen_t    i_pc_plus4,
  input  logic     i_mem_wen,
  input  logic     i_mem_ren,
  input  logic     i_mem_size,
  input  wb_sel_e  i_wb_sel,
  input  logic     i_reg_wen,
  input  reg_idx_t i_rd_idx,
  input  xlen_t    i_dmem_rdata,
  output xlen_t    o_dmem_addr,
  output xlen_t    o_dmem_wdata,
  output logic     o_dmem_wen,
  output logic     o_dmem_ren,
  output logic     o_dmem_size,
  output logic     o_wb_en,
  output reg_idx_t o_wb_idx,
  output xlen_t    o_wb_data
);

  xlen_t load_data;

  // The ALU result is the memory address.
  assign o_dmem_addr  = i_alu_result;
  assign o_dmem_wdata = i_rs2_data;
  assign o_dmem_wen   = i_mem_wen;
  assign o_dmem_ren   = i_mem_ren;
  assign o_dmem_size  = i_mem_size;

  // Word loads are sign-extended from bit 31.
  assign load_data = i_mem_size ? i_dmem_rdata :
                     {{(`NPC_XLEN-32){i_dmem_rdata[31]}}, i_dmem_rdata[31:0]};

  always_comb begin
    case (i_wb_sel)
      WB_LOAD: o_wb_data = load_data;
      WB_PC4:  o_wb_data = i_pc_plus4;
      default: o_wb_data = i_alu_result;
    endcase
  end

  assign o_wb_en  = i_reg_wen;
  assign o_wb_idx = i_rd_idx;

endmodule

//--- verilog/npc_pkg.sv
// NPC core types
package npc_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // Operations of the execute unit.
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Control transfer kinds handled by the branch unit.
  typedef enum logic [2:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE
  } br_op_e;

  // Source of the register write-back value.
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_e;

endpackage

//--- verilog/npc_regfile.sv
// NPC general purpose registers
`timescale 1ns/1ps

module npc_regfile
  import npc_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  reg_idx_t i_rs1_idx,
  input  reg_idx_t i_rs2_idx,
  input  logic     i_wen,
  input  reg_idx_t i_rd_idx,
  input  xlen_t    i_wdata,
  output xlen_t    o_rs1_data,
  output xlen_t    o_rs2_data
);

  // Register x0 has no storage.
  xlen_t regs [1:31];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd_idx != '0)) begin
      regs[i_rd_idx] <= i_wdata;
    end
  end

  // Reads see the value written at the end of the previous instruction.
  assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
  assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

endmodule
